//--- project.f
+incdir+source
source/axi_pkg.sv
source/fetch_pkg.sv
source/icache.sv
source/fetch_unit.sv
source/inst_queue.sv
source/predecode.sv
source/fetch_top.sv
dv/fetch_chk.sv
dv/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front-end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

//--- dv/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb;
    import axi_pkg::*;
    import fetch_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int ROWS = 16;

    typedef struct packed {
        logic [31:0] pc;
        logic        fault;
        logic [1:0]  n_ar;  // AR transfers expected during the fetch.
    } row_t;

    row_t stim [ROWS] = '{
        '{32'h8000_0000, 1'b0, 2'd2},  // Single-beat refill.
        '{32'hA000_0010, 1'b0, 2'd1},  // Burst refill.
        '{32'hA000_0014, 1'b0, 2'd0},
        '{32'h8000_0000, 1'b0, 2'd0},
        '{32'h9000_0000, 1'b1, 2'd1},
        '{32'h9000_0000, 1'b1, 2'd1},  // Faulted line was left unfilled.
        '{32'hA000_0100, 1'b0, 2'd1},
        '{32'hA000_0104, 1'b0, 2'd0},
        '{32'hA000_0108, 1'b0, 2'd1},
        '{32'hA000_010C, 1'b0, 2'd0},
        '{32'hA000_0110, 1'b0, 2'd1},
        '{32'hA000_0114, 1'b0, 2'd0},
        '{32'hA000_0118, 1'b0, 2'd1},
        '{32'hA000_011C, 1'b0, 2'd0},
        '{32'hA000_0120, 1'b0, 2'd1},
        '{32'hA000_0124, 1'b0, 2'd0}
    };

    logic        clk, rst, pc_valid, pc_ready;
    logic [31:0] pc;
    logic        out_valid, out_ready, out_fault;
    logic [31:0] out_inst, out_pc, out_target;
    inst_class_e out_class;
    logic        arvalid, arready, rvalid, rready, rlast;
    logic [31:0] araddr, rdata;
    logic [3:0]  arid, rid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    axi_burst_e  arburst;
    axi_resp_e   rresp;

    int          errors = 0;
    int          passed = 0;
    int          fetched = 0;
    int          ar_count = 0;
    logic        row_bad;
    logic [7:0]  last_arlen;
    axi_burst_e  last_arburst;
    logic [31:0] last_araddr;
    logic [2:0]  last_arsize;
    logic [3:0]  last_arid;
    int          row_ar [ROWS];
    logic [7:0]  row_arlen [ROWS];
    axi_burst_e  row_arburst [ROWS];
    logic [31:0] row_araddr [ROWS];
    logic [2:0]  row_arsize [ROWS];
    logic [3:0]  row_arid [ROWS];

    fetch_top fetch_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memory contents: a mixed hash, with the opcode picked by address bits 4 to 2.
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] h;
        logic [6:0]  opc;
        h = (a ^ (a >> 13)) * 32'h045D_9F3B;
        h = h ^ (h >> 16);
        case (a[4:2])
            3'd0: opc = 7'h6F;
            3'd1: opc = 7'h63;
            3'd2: opc = 7'h13;
            3'd3: opc = 7'h03;
            3'd4: opc = 7'h37;
            3'd5: opc = 7'h67;
            3'd6: opc = 7'h73;
            default: opc = 7'h7F;  // Not an RV32I major opcode.
        endcase
        return {h[31:7], opc};
    endfunction

    function automatic inst_class_e class_of(input logic [31:0] inst);
        case (inst[6:0])
            7'h03: return LOAD;
            7'h23: return STORE;
            7'h63: return BRANCH;
            7'h6F: return JAL;
            7'h67: return JALR;
            7'h13: return OP_IMM;
            7'h33: return OP;
            7'h37: return LUI;
            7'h17: return AUIPC;
            7'h73: return SYSTEM;
            default: return ILLEGAL;
        endcase
    endfunction

    function automatic logic [31:0] target_of(input logic [31:0] pc_in,
                                              input logic [31:0] inst, input logic fault);
        logic [20:0] j_off;
        logic [12:0] b_off;
        j_off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        b_off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        if (fault) return 32'd0;
        if (class_of(inst) == JAL) return pc_in + {{11{j_off[20]}}, j_off};
        if (class_of(inst) == BRANCH) return pc_in + {{19{b_off[12]}}, b_off};
        return 32'd0;
    endfunction

    task automatic after_edge();
        @(posedge clk);
        #2;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
            errors++;
            row_bad = 1'b1;
        end
    endtask

    task automatic check_row(input int i);
        logic [31:0] exp_inst;
        logic        exp_sdram;
        logic [31:0] exp_base;
        row_bad = 1'b0;
        exp_inst = stim[i].fault ? 32'd0 : mem_word(stim[i].pc);
        exp_sdram = (stim[i].pc >= `FETCH_SDRAM_BASE) && (stim[i].pc <= `FETCH_SDRAM_END);
        exp_base = stim[i].pc & ~32'(`FETCH_LINE_BYTES - 1);
        compare_value("out_pc", out_pc, stim[i].pc);
        compare_value("out_inst", out_inst, exp_inst);
        compare_value("out_fault", 32'(out_fault), 32'(stim[i].fault));
        compare_value("out_class", 32'(out_class), 32'(class_of(exp_inst)));
        compare_value("out_target", out_target, target_of(stim[i].pc, exp_inst, stim[i].fault));
        compare_value("ar_count", row_ar[i], 32'(stim[i].n_ar));
        if (row_ar[i] != 0) begin
            compare_value("arlen", 32'(row_arlen[i]), exp_sdram ? 32'd1 : 32'd0);
            // The last request of a single-beat refill points at the last word it read.
            compare_value("araddr", row_araddr[i],
                          exp_base + 32'(4 * (int'(stim[i].n_ar) - 1)));
            compare_value("arsize", 32'(row_arsize[i]), 32'd2);
            compare_value("arid", 32'(row_arid[i]), 32'd1);
            if (exp_sdram) compare_value("arburst", 32'(row_arburst[i]), 32'(BURST_INCR));
        end
        if (!row_bad) passed++;
        $display("Test %0d pc 0x%08h: %s", i, stim[i].pc, row_bad ? "mismatch" : "ok");
    endtask

    initial begin : stimulus
        int ar_start;
        void'($urandom(78));
        clk = 1'b0;
        rst = 1'b1;
        pc_valid = 1'b0;
        pc = '0;
        out_ready = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = RESP_OKAY;
        rlast = 1'b0;
        rid = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < ROWS; i++) begin
            after_edge();
            pc_valid = 1'b1;
            pc = stim[i].pc;
            do @(negedge clk); while (!pc_ready);
            ar_start = ar_count;
            after_edge();
            pc_valid = 1'b0;
            do @(negedge clk); while (!pc_ready);  // Back in IDLE once the word is pushed.
            row_ar[i] = ar_count - ar_start;
            row_arlen[i] = last_arlen;
            row_arburst[i] = last_arburst;
            row_araddr[i] = last_araddr;
            row_arsize[i] = last_arsize;
            row_arid[i] = last_arid;
            fetched = i + 1;
        end
    end

    always @(negedge clk) begin
        if (!rst && arvalid && arready) begin
            ar_count = ar_count + 1;
            last_arlen = arlen;
            last_arburst = arburst;
            last_araddr = araddr;
            last_arsize = arsize;
            last_arid = arid;
        end
    end

    // AXI memory, SLVERR on the 0x9000_0000 region.
    initial begin : axi_memory
        logic [31:0] addr;
        logic [7:0]  len;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (arvalid) begin
                repeat ($urandom % 4) after_edge();
                after_edge();
                arready = 1'b1;
                addr = araddr;
                len = arlen;
                after_edge();
                arready = 1'b0;
                for (int b = 0; b <= int'(len); b++) begin
                    repeat ($urandom % 4) after_edge();
                    rvalid = 1'b1;
                    rdata = mem_word(addr + 32'(b * 4));
                    rresp = (addr[31:28] == 4'h9) ? RESP_SLVERR : RESP_OKAY;
                    rlast = (b == int'(len));
                    rid = arid;
                    do @(negedge clk); while (!rready);
                    after_edge();
                    rvalid = 1'b0;
                    rlast = 1'b0;
                end
            end
        end
    end

    initial begin : output_monitor
        int idx;
        idx = 0;
        wait (rst === 1'b0);
        while (idx < ROWS) begin
            after_edge();
            out_ready = ($urandom % 2) == 1;
            @(negedge clk);
            if (out_valid && out_ready) begin
                wait (fetched > idx);
                check_row(idx);
                idx++;
            end
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 ROWS, passed, ROWS - passed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(ROWS * 200 * CLK_PERIOD);
        $display("Timeout: the fetches did not complete within %0d cycles", ROWS * 200);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- dv/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk (
    input logic                clk,
    input logic                rst,
    input logic                pc_ready,
    input logic                arvalid,
    input logic                arready,
    input logic [31:0]         araddr,
    input logic [7:0]          arlen,
    input axi_pkg::axi_burst_e arburst,
    input logic                rvalid,
    input logic                rready,
    input logic                rlast,
    input logic                out_valid,
    input logic                out_ready,
    input logic [31:0]         out_inst,
    input logic [31:0]         out_pc,
    input logic [31:0]         out_target,
    input logic                out_fault
);
    logic ar_open;  // Accepted AR still waiting for its last beat.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_open <= 1'b0;
        end else if (arvalid && arready) begin
            ar_open <= 1'b1;
        end else if (rvalid && rready && rlast) begin
            ar_open <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen) && $stable(arburst))
        else $error("AR request changed before it was accepted");

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_inst) && $stable(out_pc)
            && $stable(out_target) && $stable(out_fault))
        else $error("Output changed while stalled");

    r_after_ar: assert property (@(posedge clk) disable iff (rst) rready |-> ar_open)
        else $error("rready high with no accepted AR");

    idle_no_ar: assert property (@(posedge clk) disable iff (rst) !(pc_ready && arvalid))
        else $error("pc_ready and arvalid high together");

endmodule

bind fetch_top fetch_chk fetch_chk_inst (.*);

//--- source/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pc_valid,
    output logic                   pc_ready,
    input  logic [31:0]            pc,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [31:0]            out_inst,
    output logic [31:0]            out_pc,
    output fetch_pkg::inst_class_e out_class,
    output logic [31:0]            out_target,
    output logic                   out_fault,

    output logic                   arvalid,
    input  logic                   arready,
    output logic [31:0]            araddr,
    output logic [3:0]             arid,
    output logic [7:0]             arlen,
    output logic [2:0]             arsize,
    output axi_pkg::axi_burst_e    arburst,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic [31:0]            rdata,
    input  axi_pkg::axi_resp_e     rresp,
    input  logic                   rlast,
    input  logic [3:0]             rid
);
    logic                           lookup_req;
    logic [31:0]                    lookup_addr;
    logic                           lookup_hit;
    logic [31:0]                    lookup_data;
    logic                           fill_en;
    logic [31:0]                    fill_addr;
    logic [`FETCH_LINE_BYTES*8-1:0] fill_line;
    logic                           push_valid;
    logic                           push_ready;
    logic [31:0]                    push_inst;
    logic [31:0]                    push_pc;
    logic                           push_fault;
    logic                           pop_valid;
    logic                           pop_ready;
    logic [31:0]                    pop_inst;
    logic [31:0]                    pop_pc;
    logic                           pop_fault;

    fetch_unit fetch_unit_inst (.*);

    icache icache_inst (.*);

    inst_queue inst_queue_inst (.*);

    predecode predecode_inst (.*);

endmodule

//--- source/predecode.sv
`timescale 1ns/1ps

module predecode (
    input  logic                  pop_valid,
    output logic                  pop_ready,
    input  logic [31:0]           pop_inst,
    input  logic [31:0]           pop_pc,
    input  logic                  pop_fault,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [31:0]           out_inst,
    output logic [31:0]           out_pc,
    output fetch_pkg::inst_class_e out_class,
    output logic [31:0]           out_target,
    output logic                  out_fault
);
    import fetch_pkg::*;

    logic [31:0] imm_j;
    logic [31:0] imm_b;

    assign out_valid = pop_valid;
    assign pop_ready = out_ready;
    assign out_inst  = pop_inst;
    assign out_pc    = pop_pc;
    assign out_fault = pop_fault;

    assign imm_j = {{12{pop_inst[31]}}, pop_inst[19:12], pop_inst[20], pop_inst[30:21], 1'b0};
    assign imm_b = {{20{pop_inst[31]}}, pop_inst[7], pop_inst[30:25], pop_inst[11:8], 1'b0};

    always_comb begin
        case (pop_inst[6:0])
            OPC_LOAD:   out_class = LOAD;
            OPC_STORE:  out_class = STORE;
            OPC_BRANCH: out_class = BRANCH;
            OPC_JAL:    out_class = JAL;
            OPC_JALR:   out_class = JALR;
            OPC_OP_IMM: out_class = OP_IMM;
            OPC_OP:     out_class = OP;
            OPC_LUI:    out_class = LUI;
            OPC_AUIPC:  out_class = AUIPC;
            OPC_SYSTEM: out_class = SYSTEM;
            default:    out_class = ILLEGAL;
        endcase
    end

    // JALR target depends on a register, so only pc-relative jumps get one.
    always_comb begin
        out_target = 32'd0;
        if (!pop_fault) begin
            if (out_class == JAL) out_target = pop_pc + imm_j;
            else if (out_class == BRANCH) out_target = pop_pc + imm_b;
        end
    end

endmodule

//--- source/inst_queue.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module inst_queue (
    input  logic        clk,
    input  logic        rst,
    input  logic        push_valid,
    output logic        push_ready,
    input  logic [31:0] push_inst,
    input  logic [31:0] push_pc,
    input  logic        push_fault,
    output logic        pop_valid,
    input  logic        pop_ready,
    output logic [31:0] pop_inst,
    output logic [31:0] pop_pc,
    output logic        pop_fault
);
    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [31:0]      inst_mem  [DEPTH];
    logic [31:0]      pc_mem    [DEPTH];
    logic             fault_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_fire;
    logic             pop_fire;

    assign push_ready = (count != CNT_W'(DEPTH)) || pop_ready;  // Full but draining.
    assign pop_valid  = (count != '0);
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;
    assign pop_inst   = inst_mem[rd_ptr];
    assign pop_pc     = pc_mem[rd_ptr];
    assign pop_fault  = fault_mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_fire) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            inst_mem[wr_ptr]  <= push_inst;
            pc_mem[wr_ptr]    <= push_pc;
            fault_mem[wr_ptr] <= push_fault;
        end
    end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pc_valid,
    output logic                            pc_ready,
    input  logic [31:0]                     pc,

    output logic                            arvalid,
    input  logic                            arready,
    output logic [31:0]                     araddr,
    output logic [3:0]                      arid,
    output logic [7:0]                      arlen,
    output logic [2:0]                      arsize,
    output axi_pkg::axi_burst_e             arburst,
    input  logic                            rvalid,
    output logic                            rready,
    input  logic [31:0]                     rdata,
    input  axi_pkg::axi_resp_e              rresp,
    input  logic                            rlast,
    input  logic [3:0]                      rid,

    output logic                            lookup_req,
    output logic [31:0]                     lookup_addr,
    input  logic                            lookup_hit,
    input  logic [31:0]                     lookup_data,
    output logic                            fill_en,
    output logic [31:0]                     fill_addr,
    output logic [`FETCH_LINE_BYTES*8-1:0]  fill_line,

    output logic                            push_valid,
    input  logic                            push_ready,
    output logic [31:0]                     push_inst,
    output logic [31:0]                     push_pc,
    output logic                            push_fault
);
    import axi_pkg::*;
    import fetch_pkg::*;

    localparam int OFF_W  = $clog2(`FETCH_LINE_BYTES);
    localparam int WORDS  = `FETCH_LINE_BYTES / 4;
    localparam int CNT_W  = $clog2(WORDS);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(WORDS - 1);

    fetch_state_e state_q, state_d;

    logic [31:0]                    req_pc;
    logic [31:0]                    line_base;
    logic [CNT_W-1:0]               req_word;
    logic [CNT_W-1:0]               beat_cnt;
    logic [`FETCH_LINE_BYTES*8-1:0] line_buf;
    logic                           in_sdram;
    logic                           is_burst;
    logic                           line_err;
    logic                           ar_fire;
    logic                           r_fire;
    logic                           beat_err;
    logic                           err_any;
    logic                           refill_done;

    assign pc_ready    = (state_q == IDLE);
    assign lookup_req  = pc_valid && pc_ready;  // Lookup registers on the pc transfer.
    assign lookup_addr = pc;

    assign line_base = {req_pc[31:OFF_W], {OFF_W{1'b0}}};
    assign req_word  = req_pc[OFF_W-1:2];
    assign in_sdram  = (line_base >= `FETCH_SDRAM_BASE) && (line_base <= `FETCH_SDRAM_END);

    assign arid      = FETCH_ARID;
    assign arsize    = AXI_SIZE_WORD;
    assign fill_addr = line_base;
    assign fill_line = line_buf;
    assign push_pc   = req_pc;

    assign ar_fire  = arvalid && arready;
    assign r_fire   = rvalid && rready;
    assign beat_err = (rresp != RESP_OKAY) || (rid != FETCH_ARID);
    assign err_any  = line_err || beat_err;
    // A burst runs to rlast even after an error; single beats stop at once.
    assign refill_done = is_burst ? rlast : (beat_err || beat_cnt == LAST_BEAT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (pc_valid) state_d = LOOKUP;
            LOOKUP:  state_d = lookup_hit ? DELIVER : REFILL;
            REFILL:  if (r_fire && refill_done) state_d = DELIVER;
            DELIVER: if (push_ready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= IDLE;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            push_valid <= 1'b0;
            fill_en    <= 1'b0;
            beat_cnt   <= '0;
            line_err   <= 1'b0;
            is_burst   <= 1'b0;
        end else begin
            state_q <= state_d;
            fill_en <= 1'b0;
            case (state_q)
                IDLE: begin
                    beat_cnt <= '0;
                    line_err <= 1'b0;
                end
                LOOKUP: begin
                    if (lookup_hit) begin
                        push_valid <= 1'b1;
                    end else begin
                        arvalid  <= 1'b1;
                        is_burst <= in_sdram;
                    end
                end
                REFILL: begin
                    if (ar_fire) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (r_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_err) line_err <= 1'b1;
                        if (refill_done) begin
                            rready     <= 1'b0;
                            push_valid <= 1'b1;
                            fill_en    <= !err_any;  // Faulted lines stay invalid.
                        end else if (!is_burst) begin
                            rready  <= 1'b0;
                            arvalid <= 1'b1;  // Next single-beat request.
                        end
                    end
                end
                DELIVER: begin
                    if (push_ready) push_valid <= 1'b0;
                end
                default: begin
                    arvalid    <= 1'b0;
                    rready     <= 1'b0;
                    push_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (pc_valid) req_pc <= pc;
            end
            LOOKUP: begin
                araddr     <= line_base;
                arlen      <= in_sdram ? 8'(WORDS - 1) : 8'd0;
                arburst    <= in_sdram ? BURST_INCR : BURST_FIXED;
                push_inst  <= lookup_data;
                push_fault <= 1'b0;
            end
            REFILL: begin
                if (r_fire) begin
                    line_buf[beat_cnt*32 +: 32] <= rdata;
                    araddr <= araddr + 32'd4;
                    if (beat_cnt == req_word) push_inst <= rdata;
                    if (refill_done) begin
                        push_fault <= err_any;
                        if (err_any) push_inst <= 32'd0;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

//--- source/icache.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module icache (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            lookup_req,
    input  logic [31:0]                     lookup_addr,
    output logic                            lookup_hit,
    output logic [31:0]                     lookup_data,
    input  logic                            fill_en,
    input  logic [31:0]                     fill_addr,
    input  logic [`FETCH_LINE_BYTES*8-1:0]  fill_line
);
    localparam int LINES  = `FETCH_CACHE_LINES;
    localparam int OFF_W  = $clog2(`FETCH_LINE_BYTES);
    localparam int IDX_W  = $clog2(LINES);
    localparam int TAG_W  = 32 - OFF_W - IDX_W;
    localparam int LINE_W = `FETCH_LINE_BYTES * 8;

    logic [LINES-1:0]  valid;
    logic [TAG_W-1:0]  tag_mem  [LINES];
    logic [LINE_W-1:0] data_mem [LINES];

    logic [IDX_W-1:0]   lk_idx;
    logic [TAG_W-1:0]   lk_tag;
    logic [OFF_W-3:0]   lk_word;
    logic [IDX_W-1:0]   fl_idx;
    logic [TAG_W-1:0]   fl_tag;

    assign lk_idx  = lookup_addr[OFF_W +: IDX_W];
    assign lk_tag  = lookup_addr[31 -: TAG_W];
    assign lk_word = lookup_addr[OFF_W-1:2];  // Word within the line.
    assign fl_idx  = fill_addr[OFF_W +: IDX_W];
    assign fl_tag  = fill_addr[31 -: TAG_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid      <= '0;
            lookup_hit <= 1'b0;
        end else begin
            if (fill_en) begin
                valid[fl_idx] <= 1'b1;
            end
            lookup_hit <= lookup_req && valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fl_idx]  <= fl_tag;
            data_mem[fl_idx] <= fill_line;
        end
        if (lookup_req) begin
            lookup_data <= data_mem[lk_idx][lk_word*32 +: 32];
        end
    end

endmodule

//--- source/fetch_pkg.sv
package fetch_pkg;

    typedef enum logic [1:0] {
        IDLE, LOOKUP, REFILL, DELIVER
    } fetch_state_e;

    typedef enum logic [3:0] {
        LOAD, STORE, BRANCH, JAL, JALR, OP_IMM, OP, LUI, AUIPC, SYSTEM, ILLEGAL
    } inst_class_e;

    // RV32I major opcodes, bits 6 to 0.
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

endpackage

//--- source/axi_pkg.sv
package axi_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    localparam logic [3:0] FETCH_ARID = 4'd1;  // Read ID of instruction fetch.
    localparam logic [2:0] AXI_SIZE_WORD = 3'd2;  // Four bytes per beat.

endpackage

//--- source/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Cache line size in bytes, two 32-bit words.
`define FETCH_LINE_BYTES 8

// Number of direct-mapped cache lines.
`define FETCH_CACHE_LINES 16

// Instruction queue entries.
`define FETCH_QUEUE_DEPTH 4

// Burst-capable SDRAM window.
`define FETCH_SDRAM_BASE 32'hA000_0000
`define FETCH_SDRAM_END 32'hBFFF_FFFF

`endif
